// ==== include/merge_consts.svh ====
/*
 * merge block constants
 * widths of the data word fields and the bin geometry
 */

`ifndef MERGE_CONSTS_SVH
`define MERGE_CONSTS_SVH

// --------------------
// data word fields
// --------------------
`define ROW_IDX_W   8     // row index bits
`define VALUE_W     16    // data value bits

// --------------------
// bin geometry
// --------------------
`define BIN_DEPTH   4     // entries per bin
`define BIN_ADDR_W  2     // log2 of BIN_DEPTH
`define NUM_BINS    2     // bin a and bin b

// keep BIN_ADDR_W in step with BIN_DEPTH
// the sweep and the ring pointers both wrap on it

`endif

// ==== source/merge_data_pkg.sv ====
/*
 * merge data types
 * word format of the sparse-row stream and the operating mode
 */

`include "merge_consts.svh"

package merge_data_pkg;

   typedef logic [`ROW_IDX_W-1:0]  row_idx_t;   // row index
   typedef logic [`VALUE_W-1:0]    value_t;     // data value
   typedef logic [`BIN_ADDR_W-1:0] bin_addr_t;  // entry address in a bin

   // one bin entry, row index in the upper bits
   typedef struct packed {
      row_idx_t row_idx;
      value_t   value;
   } merge_word_t;

   typedef enum logic {MODE_WORK = 1'b0, MODE_POPULATE_ZERO = 1'b1} mode_t;

endpackage

// ==== source/merge_ctrl_pkg.sv ====
/*
 * merge control types
 * sweep FSM states and the merge pick encoding
 */

package merge_ctrl_pkg;

   // populate-zero sweep FSM
   typedef enum logic [1:0] {
      SWEEP_IDLE = 2'd0,   // no populate cycle seen yet
      SWEEP_RUN  = 2'd1,   // stepping through the addresses
      SWEEP_DONE = 2'd2    // all entries cleared, held until reset
   } sweep_state_t;

   // which bin head the merge stage takes this cycle
   typedef enum logic [1:0] {PICK_NONE = 2'd0, PICK_A = 2'd1, PICK_B = 2'd2} pick_t;

endpackage

// ==== source/bin_head_if.sv ====
/*
 * bin head interface
 * head word of one input bin toward the merge stage, pop strobe back
 */

`timescale 1ns/1ps

interface bin_head_if;
   import merge_data_pkg::*;

   row_idx_t row_idx;     // row index of the head word
   value_t   value;       // value of the head word
   logic     head_valid;  // head entry holds a word
   logic     pop;         // one-cycle strobe, head consumed

   // bin drives the head, takes the pop
   modport bin_side (output row_idx, output value, output head_valid, input pop);

   // merge stage reads the head, pops only while head_valid
   modport merge_side (input row_idx, input value, input head_valid, output pop);

endinterface

// ==== source/init_sweep.sv ====
/*
 * populate-zero sweep
 * steps through every bin address once while populating is enabled,
 * then holds the done flag until reset
 */

`timescale 1ns/1ps
`include "merge_consts.svh"

module init_sweep (
   input  logic                      clk,
   input  logic                      rst_b,
   input  merge_data_pkg::mode_t     mode,
   input  logic                      unit_en,
   output logic                      sweep_we,
   output merge_data_pkg::bin_addr_t sweep_addr,
   output logic                      ini_done
);
   import merge_data_pkg::*;
   import merge_ctrl_pkg::*;

   localparam bin_addr_t LAST_ADDR = bin_addr_t'(`BIN_DEPTH - 1);

   sweep_state_t state;
   bin_addr_t    addr;

   // one clear per enabled populate cycle, none once done
   assign sweep_we   = unit_en && (mode == MODE_POPULATE_ZERO) && (state != SWEEP_DONE);
   assign sweep_addr = addr;
   assign ini_done   = (state == SWEEP_DONE);   // rises at the edge after the last clear

   always_ff @(posedge clk) begin
      if (!rst_b) begin
         state <= SWEEP_IDLE;
         addr  <= '0;
      end else begin
         case (state)
            SWEEP_IDLE, SWEEP_RUN: begin
               if (sweep_we) begin
                  if (addr == LAST_ADDR) begin
                     state <= SWEEP_DONE;   // last entry cleared this cycle
                  end else begin
                     state <= SWEEP_RUN;
                     addr  <= addr + 1'b1;
                  end
               end
            end
            default: state <= SWEEP_DONE;   // done is sticky
         endcase
      end
   end

endmodule

// ==== source/input_bin.sv ====
/*
 * input bin
 * small circular memory of row-indexed words, each entry tagged valid;
 * written from outside, popped from the head, cleared by the sweep
 */

`timescale 1ns/1ps
`include "merge_consts.svh"

module input_bin #(
   parameter int BIN_ID = 0
) (
   input  logic                      clk,
   input  logic                      rst_b,
   input  merge_data_pkg::mode_t     mode,
   input  logic                      ini_done,
   input  logic                      sweep_we,
   input  merge_data_pkg::bin_addr_t sweep_addr,
   input  logic                      wr_en,
   input  logic                      wr_bin,       // one bit selects a or b
   input  merge_data_pkg::row_idx_t  wr_row_idx,
   input  merge_data_pkg::value_t    wr_value,
   bin_head_if.bin_side              head,
   output logic                      empty
);
   import merge_data_pkg::*;

   // --------------------
   // storage
   // --------------------
   merge_word_t             mem [`BIN_DEPTH];
   logic [`BIN_DEPTH-1:0]   vld;                  // valid tag per entry
   bin_addr_t               wr_ptr;
   bin_addr_t               rd_ptr;

   logic        full;
   logic        wr_acc;
   logic        pop_acc;
   merge_word_t wr_word;

   assign full    = vld[wr_ptr];        // next slot still occupied
   assign wr_acc  = wr_en && (wr_bin == 1'(BIN_ID)) && (mode == MODE_WORK)
                    && ini_done && !full;
   assign pop_acc = head.pop && head.head_valid;
   assign wr_word = '{row_idx: wr_row_idx, value: wr_value};

   // entries and tags, cleared only by the sweep
   // write slot is never the head slot while the head is valid
   always_ff @(posedge clk) begin
      if (sweep_we) begin
         mem[sweep_addr] <= '0;         // populate zero
         vld[sweep_addr] <= 1'b0;
      end else begin
         if (wr_acc) begin
            mem[wr_ptr] <= wr_word;
            vld[wr_ptr] <= 1'b1;
         end
         if (pop_acc) begin
            vld[rd_ptr] <= 1'b0;        // head consumed
         end
      end
   end

   // --------------------
   // ring pointers
   // --------------------
   always_ff @(posedge clk) begin
      if (!rst_b) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_acc)  wr_ptr <= wr_ptr + 1'b1;   // wraps at BIN_DEPTH
         if (pop_acc) rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // head view, tags are meaningless before the sweep ends
   assign head.row_idx    = mem[rd_ptr].row_idx;
   assign head.value      = mem[rd_ptr].value;
   assign head.head_valid = ini_done && vld[rd_ptr];
   assign empty           = !head.head_valid;

endmodule

// ==== source/merge_select.sv ====
/*
 * merge stage
 * compares the two bin heads by row index, pops the smaller one
 * (bin a on a tie) and registers it as the merged output
 */

`timescale 1ns/1ps

module merge_select (
   input  logic                     clk,
   input  logic                     rst_b,
   input  merge_data_pkg::mode_t    mode,
   input  logic                     ini_done,
   input  logic                     out_ready,   // level, may take a word next cycle
   bin_head_if.merge_side           head_a,
   bin_head_if.merge_side           head_b,
   output logic                     out_valid,
   output merge_data_pkg::row_idx_t out_row_idx,
   output merge_data_pkg::value_t   out_value
);
   import merge_data_pkg::*;
   import merge_ctrl_pkg::*;

   logic        go;          // stage allowed to move a word
   logic        a_first;     // a wins the compare, ties go to a
   pick_t       pick;
   merge_word_t pick_word;

   assign go      = out_ready && (mode == MODE_WORK) && ini_done;
   assign a_first = (head_a.row_idx <= head_b.row_idx);

   // --------------------
   // pick
   // --------------------
   always_comb begin
      pick = PICK_NONE;
      if (go) begin
         if (head_a.head_valid && head_b.head_valid) begin
            pick = a_first ? PICK_A : PICK_B;
         end else if (head_a.head_valid) begin
            pick = PICK_A;
         end else if (head_b.head_valid) begin
            pick = PICK_B;
         end
      end
   end

   always_comb begin
      if (pick == PICK_B) begin
         pick_word = '{row_idx: head_b.row_idx, value: head_b.value};
      end else begin
         pick_word = '{row_idx: head_a.row_idx, value: head_a.value};
      end
   end

   // exactly one pop per moving cycle
   assign head_a.pop = (pick == PICK_A);
   assign head_b.pop = (pick == PICK_B);

   // --------------------
   // output register
   // --------------------
   always_ff @(posedge clk) begin
      if (!rst_b) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= (pick != PICK_NONE);   // low the cycle after out_ready low
      end
   end

   // payload, only loaded with a real word
   always_ff @(posedge clk) begin
      if (pick != PICK_NONE) begin
         out_row_idx <= pick_word.row_idx;
         out_value   <= pick_word.value;
      end
   end

endmodule

// ==== source/merge_blk.sv ====
/*
 * two-input merge block
 * populate-zero sweep, bins a and b, and the merge stage
 * that emits one row-ordered word per cycle
 */

`timescale 1ns/1ps
`include "merge_consts.svh"

module merge_blk (
   input  logic                     clk,
   input  logic                     rst_b,
   input  merge_data_pkg::mode_t    mode,
   input  logic                     unit_en,
   input  logic                     wr_en,
   input  logic                     wr_bin,        // 0 is bin a, 1 is bin b
   input  merge_data_pkg::row_idx_t wr_row_idx,
   input  merge_data_pkg::value_t   wr_value,
   input  logic                     out_ready,
   output logic                     ini_done,
   output logic [`NUM_BINS-1:0]     bin_empty_flags,
   output logic                     out_valid,
   output merge_data_pkg::row_idx_t out_row_idx,
   output merge_data_pkg::value_t   out_value
);

   logic                      sweep_we;
   merge_data_pkg::bin_addr_t sweep_addr;

   bin_head_if head_a ();
   bin_head_if head_b ();

   // --------------------
   // init sweep
   // --------------------
   init_sweep u_sweep (
      .clk, .rst_b, .mode, .unit_en,
      .sweep_we, .sweep_addr, .ini_done
   );

   // --------------------
   // input bins
   // --------------------
   input_bin #(.BIN_ID(0)) u_bin_a (
      .clk, .rst_b, .mode, .ini_done, .sweep_we, .sweep_addr,
      .wr_en, .wr_bin, .wr_row_idx, .wr_value,
      .head(head_a), .empty(bin_empty_flags[0])
   );

   input_bin #(.BIN_ID(1)) u_bin_b (
      .clk, .rst_b, .mode, .ini_done, .sweep_we, .sweep_addr,
      .wr_en, .wr_bin, .wr_row_idx, .wr_value,
      .head(head_b), .empty(bin_empty_flags[1])
   );

   // merge stage, output throttled by out_ready
   merge_select u_merge (
      .clk, .rst_b, .mode, .ini_done, .out_ready,
      .head_a(head_a), .head_b(head_b),
      .out_valid, .out_row_idx, .out_value
   );

endmodule

// ==== bench/merge_blk_properties.sv ====
/*
 * merge block properties
 * output gating on the sweep, sticky done flag, ready throttling
 */

`timescale 1ns/1ps

module merge_blk_properties (
   input logic clk,
   input logic rst_b,
   input logic ini_done,
   input logic out_ready,
   input logic out_valid
);

   // no merged word before the sweep has finished
   no_out_before_done: assert property (
      @(posedge clk) disable iff (!rst_b) !ini_done |-> !out_valid
   ) else $error("out_valid high while ini_done is low");

   // done is held until reset
   done_sticky: assert property (
      @(posedge clk) disable iff (!rst_b) ini_done |=> ini_done
   ) else $error("ini_done fell after rising");

   // a low ready blocks the pop, so nothing leaves next cycle
   ready_throttle: assert property (
      @(posedge clk) disable iff (!rst_b) !out_ready |=> !out_valid
   ) else $error("out_valid high in the cycle after out_ready low");

endmodule

bind merge_blk merge_blk_properties u_props (.clk, .rst_b, .ini_done, .out_ready, .out_valid);

// ==== bench/merge_blk_tb.sv ====
/*
 * merge block testbench
 * sweep and populate checks, then trace-driven writes, ready patterns
 * and expected words compared against the merged output stream
 */

`timescale 1ns/1ps
`include "merge_consts.svh"

module merge_blk_tb;
   import merge_data_pkg::*;

   localparam int TRACE_MAX = 64;

   logic                  clk;
   logic                  rst_b;
   mode_t                 mode;
   logic                  unit_en;
   logic                  wr_en;
   logic                  wr_bin;
   row_idx_t              wr_row_idx;
   value_t                wr_value;
   logic                  out_ready;
   logic                  ini_done;
   logic [`NUM_BINS-1:0]  bin_empty_flags;
   logic                  out_valid;
   row_idx_t              out_row_idx;
   value_t                out_value;

   logic [31:0]  trace [TRACE_MAX];   // kind, bin or level, row, value or count
   int           n_lines;
   int           limit;
   int           cycles = 0;
   int           errors = 0;
   int           checks = 0;
   int           seed = 32'hb1cf6a50;
   merge_word_t  exp_q [$];            // words still owed by the DUT
   merge_word_t  front;

   merge_blk u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // watchdog
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
         $display("timeout, run went past %0d cycles", limit);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   // --------------------
   // output monitor
   // --------------------
   always @(negedge clk) begin
      if (rst_b && out_valid) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("output word with row 0x%0h arrived when none was expected", out_row_idx);
         end else begin
            front = exp_q.pop_front();
            check_value("out_row_idx", 32'(out_row_idx), 32'(front.row_idx));
            check_value("out_value", 32'(out_value), 32'(front.value));
         end
      end
   end

   task automatic run_line(input logic [31:0] line);
      int idle;
      case (line[31:28])
         4'h1: begin                            // bin write
            wr_en      = 1'b1;
            wr_bin     = line[24];
            wr_row_idx = line[23:16];
            wr_value   = line[15:0];
            @(negedge clk);
            wr_en = 1'b0;
            idle  = $random(seed) & 1;          // 0 or 1 idle cycles
            repeat (idle) @(negedge clk);
         end
         4'h2: begin                            // ready level held for a count
            out_ready = line[24];
            repeat (line[15:0]) begin
               @(negedge clk);
               if (!line[24]) check_value("out_valid", 32'(out_valid), 0);
            end
         end
         4'h3: exp_q.push_back(line[23:0]);
         4'h4: check_value("bin_empty_flags", 32'(bin_empty_flags), 32'(line[1:0]));
         default: begin
            errors++;
            $display("trace line of unknown kind %0h", line[31:28]);
         end
      endcase
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin
      rst_b      = 1'b0;
      mode       = MODE_WORK;
      unit_en    = 1'b0;
      wr_en      = 1'b0;
      wr_bin     = 1'b0;
      wr_row_idx = '0;
      wr_value   = '0;
      out_ready  = 1'b0;
      for (int i = 0; i < TRACE_MAX; i++) trace[i] = {4'h0, 28'(i)};   // kind 0 ends the trace
      $readmemh("bench/merge_trace.txt", trace);
      n_lines = 0;
      while (n_lines < TRACE_MAX && trace[n_lines][31:28] != 4'h0) n_lines++;
      limit = 4 * n_lines + 100;

      repeat (5) @(negedge clk);
      rst_b = 1'b1;
      @(negedge clk);
      check_value("out_valid", 32'(out_valid), 0);
      check_value("ini_done", 32'(ini_done), 0);
      check_value("bin_empty_flags", 32'(bin_empty_flags), 3);

      // writes while populating with the sweep held off by unit_en
      mode       = MODE_POPULATE_ZERO;
      wr_en      = 1'b1;
      wr_row_idx = 8'h55;
      wr_value   = 16'h5555;
      out_ready  = 1'b1;                     // merge stage open to any stray word
      repeat (2) @(negedge clk);
      check_value("ini_done", 32'(ini_done), 0);
      unit_en = 1'b1;
      for (int k = 0; k < `BIN_DEPTH; k++) begin
         check_value("ini_done", 32'(ini_done), 0);   // not early
         wr_bin = k[0];
         @(negedge clk);
      end
      check_value("ini_done", 32'(ini_done), 1);
      unit_en = 1'b0;
      @(negedge clk);
      check_value("bin_empty_flags", 32'(bin_empty_flags), 3);
      check_value("out_valid", 32'(out_valid), 0);
      wr_en = 1'b0;
      mode  = MODE_WORK;
      @(negedge clk);
      check_value("out_valid", 32'(out_valid), 0);   // a stray word would leave here
      out_ready = 1'b0;                              // trace starts throttled

      for (int t = 0; t < n_lines; t++) run_line(trace[t]);
      while (exp_q.size() != 0) @(negedge clk);   // watchdog bounds the drain
      @(negedge clk);
      check_value("out_valid", 32'(out_valid), 0);
      check_value("bin_empty_flags", 32'(bin_empty_flags), 3);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) $display("ALL TESTS PASSED");
      else $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== bench/merge_trace.txt ====
// [31:28] kind 1 write 2 ready 3 expect 4 empty flags, [24] bin or ready level
// [23:16] row index, [15:0] value or cycle count, flags in [1:0]
1001a001
1003a003
1103b003
1104b004
1005a005
40000000
20000002
3001a001
3003a003
3003b003
3004b004
3005a005
21000002
20000003
21000006
20000001
1010a010
1011a011
1012a012
1013a013
1014a014
40000002
3010a010
3011a011
3012a012
3013a013
21000008

// ==== merge_blk.f ====
+incdir+include
source/merge_data_pkg.sv
source/merge_ctrl_pkg.sv
source/bin_head_if.sv
source/init_sweep.sv
source/input_bin.sv
source/merge_select.sv
source/merge_blk.sv
bench/merge_blk_properties.sv
bench/merge_blk_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the merge block testbench with verilator, run it and scan the log

verilator --binary --timing --assert --top-module merge_blk_tb -f merge_blk.f \
   > build.log 2>&1 &&
./obj_dir/Vmerge_blk_tb > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0
